//--- verification/issue_trace.txt
# I fu rd rs1 rs2 result op_a op_b   (all fields hex, fu 0 none 1 alu 2 lsu 3 mult)
# H n   holds the commit ack low for n cycles from the next instruction on
I 1 01 00 00 00000011 00000000 00000000
I 1 02 01 00 00000022 00000011 00000000
I 3 03 01 02 00000333 00000011 00000022
I 2 04 03 03 00004444 00000333 00000333
I 1 01 04 02 00000055 00004444 00000022
I 0 00 01 01 0000dead 00000055 00000055
I 1 05 00 01 00000066 00000000 00000055
H 28
I 2 06 05 00 00000777 00000066 00000000
I 3 07 02 03 00008888 00000022 00000333
I 1 08 06 07 00000999 00000777 00008888
I 1 09 01 08 0000aaaa 00000055 00000999
I 2 02 09 09 0000bbbb 0000aaaa 0000aaaa
I 1 0a 02 04 0000cccc 0000bbbb 00004444
I 3 0b 0a 00 0000dddd 0000cccc 00000000
I 1 00 0b 06 0000eeee 0000dddd 00000777

//--- compile.f
design/issue_pkg.sv
design/scoreboard.sv
design/register_file.sv
design/issue_read_operands.sv
design/issue_stage.sv
verification/issue_stage_assert.sv
verification/tb_issue_stage.sv

//--- verification/tb_issue_stage.sv
// Issue stage testbench with trace-driven decode, unit and writeback model and commit checker

`default_nettype none

module tb_issue_stage;

  timeunit 1ns;
  timeprecision 100ps;

  import issue_pkg::*;

  localparam int MAX_INSTR   = 32;
  localparam int ACK_TIMEOUT = 200;
  localparam int MAX_CYCLES  = 3000;

  // ------------------------------
  // DUT signals
  // ------------------------------

  logic                     clk_i = 1'b0;
  logic                     arst_n_i = 1'b0;
  logic                     decoded_valid_i;
  fu_t                      decoded_fu_i;
  logic [REG_ADDR_SIZE-1:0] decoded_rd_i;
  logic [REG_ADDR_SIZE-1:0] decoded_rs1_i;
  logic [REG_ADDR_SIZE-1:0] decoded_rs2_i;
  logic                     decoded_ack_o;
  logic                     fu_valid_o;
  fu_t                      fu_type_o;
  logic [TRANS_ID_BITS-1:0] fu_trans_id_o;
  logic [XLEN-1:0]          fu_op_a_o;
  logic [XLEN-1:0]          fu_op_b_o;
  logic [REG_ADDR_SIZE-1:0] fu_rd_o;
  logic                     fu_ready_i;
  logic                     wb_valid_i;
  logic [TRANS_ID_BITS-1:0] wb_trans_id_i;
  logic [XLEN-1:0]          wb_data_i;
  logic                     commit_valid_o;
  logic [REG_ADDR_SIZE-1:0] commit_rd_o;
  logic [XLEN-1:0]          commit_data_o;
  logic [TRANS_ID_BITS-1:0] commit_trans_id_o;
  logic                     commit_ack_i;
  logic                     sb_full_o;
  logic                     stall_issue_o;

  // Trace contents and the producer of each source
  // Producer index is -1 when there is none
  logic [1:0]  tr_fu  [MAX_INSTR];
  logic [4:0]  tr_rd  [MAX_INSTR];
  logic [4:0]  tr_rs1 [MAX_INSTR];
  logic [4:0]  tr_rs2 [MAX_INSTR];
  logic [31:0] tr_res [MAX_INSTR];
  logic [31:0] tr_opa [MAX_INSTR];
  logic [31:0] tr_opb [MAX_INSTR];
  int          prod1  [MAX_INSTR];
  int          prod2  [MAX_INSTR];
  int          hold_before [MAX_INSTR];
  bit          wb_done [MAX_INSTR];

  // Model state
  int   n_instr;
  int   next_idx;
  int   cur_idx;
  int   wait_cnt;
  int   hold_cnt;
  int   inflight;
  int   disp_cnt;
  int   commits;
  int   errors;
  int   cycles;
  int   wb_idx_drv;
  bit   cur_valid;
  bit   abort;
  bit   seen_full;
  bit   any_hold;
  int   disp_q [$];
  int   pend_idx [$];
  logic [TRANS_ID_BITS-1:0] pend_id [$];

  issue_stage DUT (.*);

  always #2 clk_i = ~clk_i;

  task automatic flag_mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
    $display("[ERROR] %0t %s: got 0x%08h, expected 0x%08h", $time, name, got, exp);
    errors++;
  endtask

  // Reads the trace and records which earlier instruction feeds each source
  task automatic load_trace();
    int          fd;
    int          code;
    int          hval;
    string       line;
    logic [31:0] v [7];
    int          last_wr [32];
    for (int r = 0; r < 32; r++) begin
      last_wr[r] = -1;
    end
    fd = $fopen("verification/issue_trace.txt", "r");
    if (fd == 0) begin
      $display("Could not open the trace file");
      errors++;
      return;
    end
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      if (code == 0 || line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      if (line.getc(0) == "H" && n_instr < MAX_INSTR) begin
        code = $sscanf(line, "H %d", hval);
        hold_before[n_instr] = hval;
        any_hold = 1'b1;
      end else if (line.getc(0) == "I" && n_instr < MAX_INSTR) begin
        code = $sscanf(line, "I %h %h %h %h %h %h %h", v[0], v[1], v[2], v[3], v[4], v[5], v[6]);
        if (code != 7) begin
          $display("Malformed instruction line in the trace");
          errors++;
        end
        tr_fu[n_instr]  = v[0][1:0];
        tr_rd[n_instr]  = v[1][4:0];
        tr_rs1[n_instr] = v[2][4:0];
        tr_rs2[n_instr] = v[3][4:0];
        tr_res[n_instr] = v[4];
        tr_opa[n_instr] = v[5];
        tr_opb[n_instr] = v[6];
        // x0 has no producer
        prod1[n_instr] = (v[2][4:0] != 0) ? last_wr[v[2][4:0]] : -1;
        prod2[n_instr] = (v[3][4:0] != 0) ? last_wr[v[3][4:0]] : -1;
        if (v[1][4:0] != 0) begin
          last_wr[v[1][4:0]] = n_instr;
        end
        n_instr++;
      end
    end
    $fclose(fd);
  endtask

  // ------------------------------
  // Input drive 1 ns after the edge
  // ------------------------------

  task automatic drive_inputs();
    int k;
    if (!cur_valid && next_idx < n_instr) begin
      cur_idx   = next_idx;
      next_idx++;
      cur_valid = 1'b1;
      wait_cnt  = 0;
      // Commit hold window opens with this instruction
      if (hold_before[cur_idx] > 0) begin
        hold_cnt = hold_before[cur_idx];
      end
    end
    decoded_valid_i = cur_valid;
    decoded_fu_i    = fu_t'(tr_fu[cur_idx]);
    decoded_rd_i    = tr_rd[cur_idx];
    decoded_rs1_i   = tr_rs1[cur_idx];
    decoded_rs2_i   = tr_rs2[cur_idx];
    // Back-pressure about one cycle in four
    fu_ready_i   = ($urandom % 4) != 0;
    commit_ack_i = (hold_cnt == 0);
    // Random pending result makes writebacks come out of order
    wb_valid_i = 1'b0;
    if (pend_idx.size() > 0 && ($urandom % 2) == 0) begin
      k             = $urandom % pend_idx.size();
      wb_valid_i    = 1'b1;
      wb_trans_id_i = pend_id[k];
      wb_data_i     = tr_res[pend_idx[k]];
      wb_idx_drv    = pend_idx[k];
      pend_idx.delete(k);
      pend_id.delete(k);
    end
  endtask

  // ------------------------------
  // Sampling at the falling edge
  // ------------------------------

  task automatic observe_cycle();
    int idx;
    int p;
    bit accept;
    bit commit;
    bit hazard;
    bit must_wait;
    accept = decoded_valid_i && decoded_ack_o;
    commit = commit_valid_o && commit_ack_i;
    if (sb_full_o) begin
      seen_full = 1'b1;
    end
    // Full exactly when four instructions are tracked
    if (sb_full_o !== (inflight == NR_SB_ENTRIES)) begin
      flag_mismatch("sb_full_o", sb_full_o, inflight == NR_SB_ENTRIES);
    end
    if (sb_full_o && decoded_ack_o) begin
      flag_mismatch("decoded_ack_o", decoded_ack_o, 0);
    end
    // A source producer still missing its writeback
    hazard = 1'b0;
    for (int s = 0; s < 2; s++) begin
      p = (s == 0) ? prod1[cur_idx] : prod2[cur_idx];
      if (p >= 0 && !wb_done[p]) begin
        hazard = 1'b1;
      end
    end
    // Offered instruction waits on a hazard, a full scoreboard or a stalled dispatch slot
    must_wait = hazard || (inflight == NR_SB_ENTRIES) || (disp_q.size() != 0 && !fu_ready_i);
    if (decoded_ack_o !== (cur_valid && !must_wait)) begin
      flag_mismatch("decoded_ack_o", decoded_ack_o, cur_valid && !must_wait);
    end
    if (stall_issue_o !== (cur_valid && must_wait)) begin
      flag_mismatch("stall_issue_o", stall_issue_o, cur_valid && must_wait);
    end
    // Dispatch transfer carries the oldest accepted instruction
    if (fu_valid_o && fu_ready_i) begin
      if (disp_q.size() == 0) begin
        $display("Dispatch transfer seen with no accepted instruction waiting");
        errors++;
      end else begin
        idx = disp_q.pop_front();
        if (fu_op_a_o !== tr_opa[idx]) flag_mismatch("fu_op_a_o", fu_op_a_o, tr_opa[idx]);
        if (fu_op_b_o !== tr_opb[idx]) flag_mismatch("fu_op_b_o", fu_op_b_o, tr_opb[idx]);
        if (fu_rd_o !== tr_rd[idx]) flag_mismatch("fu_rd_o", fu_rd_o, tr_rd[idx]);
        if (fu_type_o !== tr_fu[idx]) flag_mismatch("fu_type_o", fu_type_o, tr_fu[idx]);
        if (fu_trans_id_o !== TRANS_ID_BITS'(disp_cnt)) begin
          flag_mismatch("fu_trans_id_o", fu_trans_id_o, TRANS_ID_BITS'(disp_cnt));
        end
        pend_idx.push_back(idx);
        pend_id.push_back(fu_trans_id_o);
        disp_cnt++;
      end
    end
    // Sources must have their producer written back at an earlier edge
    if (accept) begin
      if (hazard) begin
        $display("Instruction %0d accepted before the writeback of its source producer", cur_idx);
        errors++;
      end
      disp_q.push_back(cur_idx);
      cur_valid = 1'b0;
    end else if (cur_valid) begin
      wait_cnt++;
      if (wait_cnt > ACK_TIMEOUT) begin
        $display("Timeout: instruction %0d was never accepted", cur_idx);
        errors++;
        abort = 1'b1;
      end
    end
    if (wb_valid_i) begin
      wb_done[wb_idx_drv] = 1'b1;
    end
    // Commits in trace order
    if (commit) begin
      if (commits >= n_instr) begin
        $display("Commit seen after the whole trace had committed");
        errors++;
      end else begin
        if (commit_rd_o !== tr_rd[commits]) flag_mismatch("commit_rd_o", commit_rd_o, tr_rd[commits]);
        if (commit_data_o !== tr_res[commits]) begin
          flag_mismatch("commit_data_o", commit_data_o, tr_res[commits]);
        end
        if (commit_trans_id_o !== TRANS_ID_BITS'(commits)) begin
          flag_mismatch("commit_trans_id_o", commit_trans_id_o, TRANS_ID_BITS'(commits));
        end
      end
      commits++;
    end
    inflight = inflight + accept - commit;
    if (hold_cnt > 0) begin
      hold_cnt--;
    end
  endtask

  initial begin
    int total;
    void'($urandom(32'h837b));
    arst_n_i        = 1'b0;
    decoded_valid_i = 1'b0;
    decoded_fu_i    = FU_NONE;
    decoded_rd_i    = '0;
    decoded_rs1_i   = '0;
    decoded_rs2_i   = '0;
    fu_ready_i      = 1'b0;
    wb_valid_i      = 1'b0;
    wb_trans_id_i   = '0;
    wb_data_i       = '0;
    commit_ack_i    = 1'b0;
    load_trace();
    repeat (2) @(posedge clk_i);
    #1 arst_n_i = 1'b1;
    @(negedge clk_i);
    // Idle outputs after reset
    if (decoded_ack_o !== 1'b0) flag_mismatch("decoded_ack_o", decoded_ack_o, 0);
    if (fu_valid_o !== 1'b0) flag_mismatch("fu_valid_o", fu_valid_o, 0);
    if (commit_valid_o !== 1'b0) flag_mismatch("commit_valid_o", commit_valid_o, 0);
    if (sb_full_o !== 1'b0) flag_mismatch("sb_full_o", sb_full_o, 0);
    while (!abort && commits < n_instr) begin
      @(posedge clk_i);
      #1;
      drive_inputs();
      @(negedge clk_i);
      observe_cycle();
      cycles++;
      if (cycles > MAX_CYCLES) begin
        $display("Timeout: only %0d of %0d instructions committed", commits, n_instr);
        errors++;
        abort = 1'b1;
      end
    end
    if (any_hold && !seen_full) begin
      $display("Scoreboard never reported full while commits were held off");
      errors++;
    end
    if (n_instr == 0) begin
      $display("No instructions were read from the trace");
      errors++;
    end
    total = errors + DUT.i_issue_read_operands.dispatch_chk.fail_cnt
          + DUT.i_scoreboard.commit_chk.fail_cnt;
    $display("Summary: %0d committed, %0d testbench errors, %0d total errors", commits, errors, total);
    if (total == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/issue_stage_assert.sv
// Bound assertions: hold under back-pressure, no allocation while full, idle after reset

`default_nettype none

module issue_stage_assert #(
  parameter int unsigned DATA_W = 8
) (
  input wire logic              clk_i,
  input wire logic              arst_n_i,
  // Handshake whose payload must hold while not accepted
  input wire logic              valid_i,
  input wire logic              ready_i,
  input wire logic [DATA_W-1:0] data_i,
  // Scoreboard allocation against the full flag
  input wire logic              alloc_i,
  input wire logic              full_i,
  // Output that must be low right after reset
  input wire logic              idle_after_reset_i
);

  timeunit 1ns;
  timeprecision 100ps;

  // Failure count, read by the testbench at the end of the run
  int unsigned fail_cnt = 0;

  // ------------------------------
  // Properties
  // ------------------------------

  // Stalled transfer keeps valid high and the payload unchanged
  a_hold_stalled: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (valid_i && !ready_i) |=> (valid_i && $stable(data_i)))
    else begin
      $error("payload changed or valid dropped while the receiver stalled");
      fail_cnt++;
    end

  // A full scoreboard takes no new entry
  a_no_alloc_full: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !(alloc_i && full_i))
    else begin
      $error("allocation while the scoreboard is full");
      fail_cnt++;
    end

  // First edge after release sees an idle output
  a_idle_after_reset: assert property (@(posedge clk_i)
    $rose(arst_n_i) |-> !idle_after_reset_i)
    else begin
      $error("output high in the first cycle after reset");
      fail_cnt++;
    end

endmodule

// Dispatch side: payload is the whole dispatch register
bind issue_read_operands issue_stage_assert #(
  .DATA_W(4 + issue_pkg::TRANS_ID_BITS + 2 * issue_pkg::XLEN + issue_pkg::REG_ADDR_SIZE - 2)
) dispatch_chk (
  .clk_i             (clk_i),
  .arst_n_i          (arst_n_i),
  .valid_i           (fu_valid_o),
  .ready_i           (fu_ready_i),
  .data_i            ({fu_type_o, fu_trans_id_o, fu_op_a_o, fu_op_b_o, fu_rd_o}),
  .alloc_i           (alloc_o),
  .full_i            (sb_full_i),
  .idle_after_reset_i(fu_valid_o)
);

// Commit side: head entry holds until acknowledged
bind scoreboard issue_stage_assert #(
  .DATA_W(issue_pkg::REG_ADDR_SIZE + issue_pkg::XLEN + issue_pkg::TRANS_ID_BITS)
) commit_chk (
  .clk_i             (clk_i),
  .arst_n_i          (arst_n_i),
  .valid_i           (commit_valid_o),
  .ready_i           (commit_ack_i),
  .data_i            ({commit_rd_o, commit_data_o, commit_trans_id_o}),
  .alloc_i           (alloc_i),
  .full_i            (sb_full_o),
  .idle_after_reset_i(commit_valid_o)
);

`default_nettype wire

//--- design/issue_stage.sv
// Issue stage top: scoreboard, register file and issue logic wired together

`default_nettype none

module issue_stage (
  input  wire logic                               clk_i,
  input  wire logic                               arst_n_i,
  // Decode
  input  wire logic                               decoded_valid_i,
  input  wire issue_pkg::fu_t                     decoded_fu_i,
  input  wire logic [issue_pkg::REG_ADDR_SIZE-1:0] decoded_rd_i,
  input  wire logic [issue_pkg::REG_ADDR_SIZE-1:0] decoded_rs1_i,
  input  wire logic [issue_pkg::REG_ADDR_SIZE-1:0] decoded_rs2_i,
  output logic                                    decoded_ack_o,
  // Dispatch
  output logic                                    fu_valid_o,
  output issue_pkg::fu_t                          fu_type_o,
  output logic      [issue_pkg::TRANS_ID_BITS-1:0] fu_trans_id_o,
  output logic      [issue_pkg::XLEN-1:0]          fu_op_a_o,
  output logic      [issue_pkg::XLEN-1:0]          fu_op_b_o,
  output logic      [issue_pkg::REG_ADDR_SIZE-1:0] fu_rd_o,
  input  wire logic                               fu_ready_i,
  // Writeback
  input  wire logic                               wb_valid_i,
  input  wire logic [issue_pkg::TRANS_ID_BITS-1:0] wb_trans_id_i,
  input  wire logic [issue_pkg::XLEN-1:0]          wb_data_i,
  // Commit
  output logic                                    commit_valid_o,
  output logic      [issue_pkg::REG_ADDR_SIZE-1:0] commit_rd_o,
  output logic      [issue_pkg::XLEN-1:0]          commit_data_o,
  output logic      [issue_pkg::TRANS_ID_BITS-1:0] commit_trans_id_o,
  input  wire logic                               commit_ack_i,
  // Status
  output logic                                    sb_full_o,
  output logic                                    stall_issue_o
);

  import issue_pkg::*;

  // ------------------------------
  // Issue <-> scoreboard and RF
  // ------------------------------

  logic [REG_ADDR_SIZE-1:0] rs1_addr;
  logic [REG_ADDR_SIZE-1:0] rs2_addr;
  logic                     rs1_clobbered;
  logic                     rs1_fwd_valid;
  logic [XLEN-1:0]          rs1_fwd_data;
  logic                     rs2_clobbered;
  logic                     rs2_fwd_valid;
  logic [XLEN-1:0]          rs2_fwd_data;
  logic                     alloc;
  logic [REG_ADDR_SIZE-1:0] alloc_rd;
  logic [TRANS_ID_BITS-1:0] alloc_id;
  logic [XLEN-1:0]          rf_rdata_a;
  logic [XLEN-1:0]          rf_rdata_b;

  // Commit ack retires the head into the register file
  logic rf_we;
  assign rf_we = commit_ack_i & commit_valid_o;

  scoreboard i_scoreboard (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .alloc_i          (alloc),
    .alloc_rd_i       (alloc_rd),
    .alloc_id_o       (alloc_id),
    .sb_full_o        (sb_full_o),
    .rs1_addr_i       (rs1_addr),
    .rs1_clobbered_o  (rs1_clobbered),
    .rs1_fwd_valid_o  (rs1_fwd_valid),
    .rs1_fwd_data_o   (rs1_fwd_data),
    .rs2_addr_i       (rs2_addr),
    .rs2_clobbered_o  (rs2_clobbered),
    .rs2_fwd_valid_o  (rs2_fwd_valid),
    .rs2_fwd_data_o   (rs2_fwd_data),
    .wb_valid_i       (wb_valid_i),
    .wb_trans_id_i    (wb_trans_id_i),
    .wb_data_i        (wb_data_i),
    .commit_valid_o   (commit_valid_o),
    .commit_rd_o      (commit_rd_o),
    .commit_data_o    (commit_data_o),
    .commit_trans_id_o(commit_trans_id_o),
    .commit_ack_i     (commit_ack_i)
  );

  register_file i_register_file (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .raddr_a_i(rs1_addr),
    .raddr_b_i(rs2_addr),
    .rdata_a_o(rf_rdata_a),
    .rdata_b_o(rf_rdata_b),
    .we_i     (rf_we),
    .waddr_i  (commit_rd_o),
    .wdata_i  (commit_data_o)
  );

  issue_read_operands i_issue_read_operands (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .decoded_valid_i(decoded_valid_i),
    .decoded_fu_i   (decoded_fu_i),
    .decoded_rd_i   (decoded_rd_i),
    .decoded_rs1_i  (decoded_rs1_i),
    .decoded_rs2_i  (decoded_rs2_i),
    .decoded_ack_o  (decoded_ack_o),
    .rs1_addr_o     (rs1_addr),
    .rs1_clobbered_i(rs1_clobbered),
    .rs1_fwd_valid_i(rs1_fwd_valid),
    .rs1_fwd_data_i (rs1_fwd_data),
    .rs2_addr_o     (rs2_addr),
    .rs2_clobbered_i(rs2_clobbered),
    .rs2_fwd_valid_i(rs2_fwd_valid),
    .rs2_fwd_data_i (rs2_fwd_data),
    .alloc_o        (alloc),
    .alloc_rd_o     (alloc_rd),
    .alloc_id_i     (alloc_id),
    .sb_full_i      (sb_full_o),
    .rf_rdata_a_i   (rf_rdata_a),
    .rf_rdata_b_i   (rf_rdata_b),
    .fu_valid_o     (fu_valid_o),
    .fu_type_o      (fu_type_o),
    .fu_trans_id_o  (fu_trans_id_o),
    .fu_op_a_o      (fu_op_a_o),
    .fu_op_b_o      (fu_op_b_o),
    .fu_rd_o        (fu_rd_o),
    .fu_ready_i     (fu_ready_i),
    .stall_issue_o  (stall_issue_o)
  );

endmodule

`default_nettype wire

//--- design/issue_read_operands.sv
// Issue and read operands: hazard check, operand selection, registered dispatch to the units

`default_nettype none

module issue_read_operands (
  input  wire logic                               clk_i,
  input  wire logic                               arst_n_i,
  // Decode handshake, valid/ack
  input  wire logic                               decoded_valid_i,
  input  wire issue_pkg::fu_t                     decoded_fu_i,
  input  wire logic [issue_pkg::REG_ADDR_SIZE-1:0] decoded_rd_i,
  input  wire logic [issue_pkg::REG_ADDR_SIZE-1:0] decoded_rs1_i,
  input  wire logic [issue_pkg::REG_ADDR_SIZE-1:0] decoded_rs2_i,
  output logic                                    decoded_ack_o,
  // Scoreboard lookup, addresses also go to the register file
  output logic      [issue_pkg::REG_ADDR_SIZE-1:0] rs1_addr_o,
  input  wire logic                               rs1_clobbered_i,
  input  wire logic                               rs1_fwd_valid_i,
  input  wire logic [issue_pkg::XLEN-1:0]          rs1_fwd_data_i,
  output logic      [issue_pkg::REG_ADDR_SIZE-1:0] rs2_addr_o,
  input  wire logic                               rs2_clobbered_i,
  input  wire logic                               rs2_fwd_valid_i,
  input  wire logic [issue_pkg::XLEN-1:0]          rs2_fwd_data_i,
  // Scoreboard allocation
  output logic                                    alloc_o,
  output logic      [issue_pkg::REG_ADDR_SIZE-1:0] alloc_rd_o,
  input  wire logic [issue_pkg::TRANS_ID_BITS-1:0] alloc_id_i,
  input  wire logic                               sb_full_i,
  // Register file read data
  input  wire logic [issue_pkg::XLEN-1:0]          rf_rdata_a_i,
  input  wire logic [issue_pkg::XLEN-1:0]          rf_rdata_b_i,
  // Dispatch to the functional units, ready/valid
  output logic                                    fu_valid_o,
  output issue_pkg::fu_t                          fu_type_o,
  output logic      [issue_pkg::TRANS_ID_BITS-1:0] fu_trans_id_o,
  output logic      [issue_pkg::XLEN-1:0]          fu_op_a_o,
  output logic      [issue_pkg::XLEN-1:0]          fu_op_b_o,
  output logic      [issue_pkg::REG_ADDR_SIZE-1:0] fu_rd_o,
  input  wire logic                               fu_ready_i,
  // Valid instruction held back this cycle
  output logic                                    stall_issue_o
);

  import issue_pkg::*;

  // ------------------------------
  // Operand read and hazards
  // ------------------------------

  logic            rs1_blocked;
  logic            rs2_blocked;
  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic            dispatch_free;
  logic            accept;

  // Dispatch register
  logic                     fu_valid_q;
  fu_t                      fu_type_q;
  logic [TRANS_ID_BITS-1:0] fu_trans_id_q;
  logic [XLEN-1:0]          fu_op_a_q;
  logic [XLEN-1:0]          fu_op_b_q;
  logic [REG_ADDR_SIZE-1:0] fu_rd_q;

  assign rs1_addr_o = decoded_rs1_i;
  assign rs2_addr_o = decoded_rs2_i;

  // Waiting only on a producer whose result has not come back
  assign rs1_blocked = rs1_clobbered_i & ~rs1_fwd_valid_i;
  assign rs2_blocked = rs2_clobbered_i & ~rs2_fwd_valid_i;

  // Forwarded result beats the stale register file value
  assign op_a = rs1_fwd_valid_i ? rs1_fwd_data_i : rf_rdata_a_i;
  assign op_b = rs2_fwd_valid_i ? rs2_fwd_data_i : rf_rdata_b_i;

  // Dispatch slot is empty or drains this cycle
  assign dispatch_free = ~fu_valid_q | fu_ready_i;

  assign accept = decoded_valid_i & ~rs1_blocked & ~rs2_blocked & ~sb_full_i & dispatch_free;

  assign decoded_ack_o = accept;
  assign stall_issue_o = decoded_valid_i & ~accept;

  // Slot taken in the same cycle as the ack
  assign alloc_o    = accept;
  assign alloc_rd_o = decoded_rd_i;

  // ------------------------------
  // Dispatch register
  // ------------------------------

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      fu_valid_q <= 1'b0;
    end else if (accept) begin
      fu_valid_q <= 1'b1;
    end else if (fu_ready_i) begin
      fu_valid_q <= 1'b0;
    end
  end

  // Payload loads only on acceptance, so it holds under back-pressure
  always_ff @(posedge clk_i) begin
    if (accept) begin
      fu_type_q     <= decoded_fu_i;
      fu_trans_id_q <= alloc_id_i;
      fu_op_a_q     <= op_a;
      fu_op_b_q     <= op_b;
      fu_rd_q       <= decoded_rd_i;
    end
  end

  assign fu_valid_o    = fu_valid_q;
  assign fu_type_o     = fu_type_q;
  assign fu_trans_id_o = fu_trans_id_q;
  assign fu_op_a_o     = fu_op_a_q;
  assign fu_op_b_o     = fu_op_b_q;
  assign fu_rd_o       = fu_rd_q;

endmodule

`default_nettype wire

//--- design/register_file.sv
// Register file: 32 integer registers, two combinational read ports, one write port

`default_nettype none

module register_file (
  input  wire logic                               clk_i,
  input  wire logic                               arst_n_i,
  // Read ports
  input  wire logic [issue_pkg::REG_ADDR_SIZE-1:0] raddr_a_i,
  input  wire logic [issue_pkg::REG_ADDR_SIZE-1:0] raddr_b_i,
  output logic      [issue_pkg::XLEN-1:0]          rdata_a_o,
  output logic      [issue_pkg::XLEN-1:0]          rdata_b_o,
  // Write port, driven by commit
  input  wire logic                               we_i,
  input  wire logic [issue_pkg::REG_ADDR_SIZE-1:0] waddr_i,
  input  wire logic [issue_pkg::XLEN-1:0]          wdata_i
);

  import issue_pkg::*;

  localparam int unsigned NR_REGS = 2 ** REG_ADDR_SIZE;

  logic [NR_REGS-1:0][XLEN-1:0] regs_q;

  // ------------------------------
  // Write
  // ------------------------------

  // x0 is never written
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      regs_q <= '0;
    end else if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // ------------------------------
  // Read
  // ------------------------------

  // Register 0 reads as zero regardless of storage
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

`default_nettype wire

//--- design/scoreboard.sv
// Scoreboard: circular buffer of in-flight instructions, clobber lookup, forwarding, commit

`default_nettype none

module scoreboard (
  input  wire logic                               clk_i,
  input  wire logic                               arst_n_i,
  // Allocation from issue
  input  wire logic                               alloc_i,
  input  wire logic [issue_pkg::REG_ADDR_SIZE-1:0] alloc_rd_i,
  output logic      [issue_pkg::TRANS_ID_BITS-1:0] alloc_id_o,
  output logic                                    sb_full_o,
  // Source lookup
  input  wire logic [issue_pkg::REG_ADDR_SIZE-1:0] rs1_addr_i,
  output logic                                    rs1_clobbered_o,
  output logic                                    rs1_fwd_valid_o,
  output logic      [issue_pkg::XLEN-1:0]          rs1_fwd_data_o,
  input  wire logic [issue_pkg::REG_ADDR_SIZE-1:0] rs2_addr_i,
  output logic                                    rs2_clobbered_o,
  output logic                                    rs2_fwd_valid_o,
  output logic      [issue_pkg::XLEN-1:0]          rs2_fwd_data_o,
  // Writeback, accepted every cycle
  input  wire logic                               wb_valid_i,
  input  wire logic [issue_pkg::TRANS_ID_BITS-1:0] wb_trans_id_i,
  input  wire logic [issue_pkg::XLEN-1:0]          wb_data_i,
  // Commit of the head entry
  output logic                                    commit_valid_o,
  output logic      [issue_pkg::REG_ADDR_SIZE-1:0] commit_rd_o,
  output logic      [issue_pkg::XLEN-1:0]          commit_data_o,
  output logic      [issue_pkg::TRANS_ID_BITS-1:0] commit_trans_id_o,
  input  wire logic                               commit_ack_i
);

  import issue_pkg::*;

  // Entry count needs one extra bit to tell full from empty
  localparam int unsigned CNT_W = TRANS_ID_BITS + 1;

  // ------------------------------
  // Pointers and per-slot state
  // ------------------------------

  logic [TRANS_ID_BITS-1:0] head_q;
  logic [TRANS_ID_BITS-1:0] tail_q;
  logic [CNT_W-1:0]         count_q;

  // Control flags, cleared at reset
  logic [NR_SB_ENTRIES-1:0] busy_q;
  logic [NR_SB_ENTRIES-1:0] done_q;

  // Payload per slot
  logic [REG_ADDR_SIZE-1:0] rd_q     [NR_SB_ENTRIES];
  logic [XLEN-1:0]          result_q [NR_SB_ENTRIES];

  // Head leaves only when it is finished
  logic commit_fire;

  // Lookup per source port, index 0 is rs1
  logic [REG_ADDR_SIZE-1:0] rs_addr [2];
  logic                     rs_clob [2];
  logic                     rs_fv   [2];
  logic [XLEN-1:0]          rs_fd   [2];

  assign alloc_id_o = tail_q;
  assign sb_full_o  = (count_q == CNT_W'(NR_SB_ENTRIES));

  // Head is presented once its result is back
  assign commit_valid_o    = busy_q[head_q] & done_q[head_q];
  assign commit_rd_o       = rd_q[head_q];
  assign commit_data_o     = result_q[head_q];
  assign commit_trans_id_o = head_q;
  assign commit_fire       = commit_valid_o & commit_ack_i;

  // ------------------------------
  // Clobber and forward search
  // ------------------------------

  assign rs_addr[0] = rs1_addr_i;
  assign rs_addr[1] = rs2_addr_i;

  // Walk from youngest (tail - 1) to oldest, first hit wins
  // x0 is never a destination here
  always_comb begin
    logic [TRANS_ID_BITS-1:0] idx;
    logic                     found;
    for (int p = 0; p < 2; p++) begin
      found      = 1'b0;
      rs_clob[p] = 1'b0;
      rs_fv[p]   = 1'b0;
      rs_fd[p]   = '0;
      for (int i = 0; i < NR_SB_ENTRIES; i++) begin
        idx = tail_q - TRANS_ID_BITS'(i) - 1'b1;
        if (!found && busy_q[idx] && (rs_addr[p] != '0) && (rd_q[idx] == rs_addr[p])) begin
          found      = 1'b1;
          rs_clob[p] = 1'b1;
          // Finished producer can feed the operand directly
          rs_fv[p]   = done_q[idx];
          rs_fd[p]   = result_q[idx];
        end
      end
    end
  end

  assign rs1_clobbered_o = rs_clob[0];
  assign rs1_fwd_valid_o = rs_fv[0];
  assign rs1_fwd_data_o  = rs_fd[0];
  assign rs2_clobbered_o = rs_clob[1];
  assign rs2_fwd_valid_o = rs_fv[1];
  assign rs2_fwd_data_o  = rs_fd[1];

  // ------------------------------
  // Control state update
  // ------------------------------

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
      busy_q  <= '0;
      done_q  <= '0;
    end else begin
      // New entry at the tail, result pending
      if (alloc_i) begin
        busy_q[tail_q] <= 1'b1;
        done_q[tail_q] <= 1'b0;
        tail_q         <= tail_q + 1'b1;
      end
      // Results may come back out of order
      if (wb_valid_i) begin
        done_q[wb_trans_id_i] <= 1'b1;
      end
      // Retire the oldest entry
      if (commit_fire) begin
        busy_q[head_q] <= 1'b0;
        done_q[head_q] <= 1'b0;
        head_q         <= head_q + 1'b1;
      end
      count_q <= count_q + CNT_W'(alloc_i) - CNT_W'(commit_fire);
    end
  end

  // Destination and result storage
  always_ff @(posedge clk_i) begin
    if (alloc_i) begin
      rd_q[tail_q] <= alloc_rd_i;
    end
    if (wb_valid_i) begin
      result_q[wb_trans_id_i] <= wb_data_i;
    end
  end

endmodule

`default_nettype wire

//--- design/issue_pkg.sv
// Issue stage package: data and register widths, scoreboard size, functional unit encoding

`default_nettype none

package issue_pkg;

  // ------------------------------
  // Datapath widths
  // ------------------------------

  // Integer register and result width
  localparam int unsigned XLEN = 32;

  // Architectural register index, 32 integer registers
  localparam int unsigned REG_ADDR_SIZE = 5;

  // ------------------------------
  // Scoreboard sizing
  // ------------------------------

  // In-flight instructions tracked between issue and commit
  localparam int unsigned NR_SB_ENTRIES = 4;

  // Transaction id is the scoreboard slot index
  // Must satisfy 2**TRANS_ID_BITS == NR_SB_ENTRIES so pointers wrap naturally
  localparam int unsigned TRANS_ID_BITS = 2;

  // ------------------------------
  // Functional unit classes
  // ------------------------------

  // Unit needed by an instruction, carried with it into dispatch
  typedef enum logic [1:0] {
    // No unit, result still comes back over writeback
    FU_NONE = 2'd0,
    // Integer ALU
    FU_ALU  = 2'd1,
    // Load-store unit
    FU_LSU  = 2'd2,
    // Multiplier
    FU_MULT = 2'd3
  } fu_t;

endpackage

`default_nettype wire
